/* vlog.f */
+incdir+include
+incdir+tests
verilog/backend_types_pkg.sv
verilog/axil_pkg.sv
verilog/rename_regfile.sv
verilog/reorder_buffer.sv
verilog/regfile_axil_reader.sv
verilog/ooo_backend_top.sv
tests/tb_ooo_backend.sv

/* Bender.yml */
package:
  name: ooo_backend

sources:
  - include_dirs:
      - include
    files:
      - verilog/backend_types_pkg.sv
      - verilog/axil_pkg.sv
      - verilog/rename_regfile.sv
      - verilog/reorder_buffer.sv
      - verilog/regfile_axil_reader.sv
      - verilog/ooo_backend_top.sv

  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/tb_ooo_backend.sv

/* tests/tb_vectors.svh */
// columns   op, a, b, c, exp_tag, exp_resp
//   OP_ISSUE  a = rs1, b = rs2, c = rd, exp_tag = expected op_tag
//   OP_WB     a = tag, data comes from $urandom
//   OP_WB_ALL every outstanding tag once, shuffled
//   OP_READ   a = byte address, b = cycles with r_ready low, exp_resp = rresp
//   OP_IDLE   a = cycle count
typedef enum logic [2:0] {
    OP_ISSUE,
    OP_WB,
    OP_WB_ALL,
    OP_READ,
    OP_IDLE
} vec_op_e;

typedef struct packed {
    vec_op_e                     op;
    logic [7:0]                  a;
    logic [4:0]                  b;
    logic [4:0]                  c;
    backend_types_pkg::rob_tag_t exp_tag;
    axil_pkg::axil_resp_e        exp_resp;
} vec_t;

vec_t vectors [$];

task automatic load_vectors();
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset state, dependency chain, x0
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vectors.push_back('{OP_READ, 8'h00, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_READ, 8'h7C, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd3, 5'd7, 5'd1, 3'd1, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd1, 5'd0, 5'd2, 3'd2, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd2, 5'd1, 5'd3, 3'd3, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd0, 5'd0, 5'd0, 3'd4, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd3, 5'd3, 5'd3, 3'd5, axil_pkg::OKAY});  // rs == rd
    // shuffled completion, in-order retirement
    vectors.push_back('{OP_WB_ALL, 8'd0, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd10, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_READ, 8'h04, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_READ, 8'h0C, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd3, 5'd1, 5'd6, 3'd6, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd2, 5'd6, 5'd7, 3'd7, axil_pkg::OKAY});
    vectors.push_back('{OP_WB_ALL, 8'd0, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd8, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two writers of x5
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vectors.push_back('{OP_ISSUE, 8'd0, 5'd0, 5'd5, 3'd1, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd5, 5'd0, 5'd5, 3'd2, axil_pkg::OKAY});
    vectors.push_back('{OP_WB, 8'd1, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd4, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd5, 5'd5, 5'd8, 3'd3, axil_pkg::OKAY});  // still tag 2
    vectors.push_back('{OP_WB, 8'd2, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd4, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd5, 5'd0, 5'd9, 3'd4, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd8, 5'd9, 5'd10, 3'd5, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd10, 5'd5, 5'd11, 3'd6, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd0, 5'd0, 5'd0, 3'd7, axil_pkg::OKAY});
    vectors.push_back('{OP_WB_ALL, 8'd0, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd10, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_READ, 8'h14, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    // fill all seven tags, then free the head
    vectors.push_back('{OP_ISSUE, 8'd11, 5'd12, 5'd12, 3'd1, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd12, 5'd0, 5'd13, 3'd2, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd13, 5'd12, 5'd14, 3'd3, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd14, 5'd0, 5'd15, 3'd4, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd15, 5'd0, 5'd16, 3'd5, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd16, 5'd0, 5'd17, 3'd6, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd17, 5'd0, 5'd18, 3'd7, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd3, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_WB, 8'd1, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_ISSUE, 8'd12, 5'd18, 5'd19, 3'd1, axil_pkg::OKAY});  // wraps
    vectors.push_back('{OP_WB_ALL, 8'd0, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_IDLE, 8'd12, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
    // bad addresses and a stalled r_ready
    vectors.push_back('{OP_READ, 8'h80, 5'd3, 5'd0, 3'd0, axil_pkg::SLVERR});
    vectors.push_back('{OP_READ, 8'h0E, 5'd4, 5'd0, 3'd0, axil_pkg::SLVERR});
    vectors.push_back('{OP_READ, 8'h30, 5'd2, 5'd0, 3'd0, axil_pkg::OKAY});
    vectors.push_back('{OP_READ, 8'h4C, 5'd0, 5'd0, 3'd0, axil_pkg::OKAY});
endtask

/* tests/tb_ooo_backend.sv */
`include "backend_consts.svh"

module tb_ooo_backend;

    localparam int TIMEOUT = 50;

    logic                          clk;
    logic                          rst;
    logic                          issue_valid;
    backend_types_pkg::issue_req_t issue_req;
    logic                          issue_ready;
    logic                          op_valid;
    backend_types_pkg::operand_t   op1;
    backend_types_pkg::operand_t   op2;
    backend_types_pkg::rob_tag_t   op_tag;
    logic                          wb_valid;
    backend_types_pkg::wb_t        wb;
    logic                          ar_valid;
    axil_pkg::axil_ar_t            ar;
    logic                          ar_ready;
    logic                          r_valid;
    axil_pkg::axil_r_t             r;
    logic                          r_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    backend_types_pkg::xlen_t    m_regs [`BE_NUM_REGS];
    backend_types_pkg::rob_tag_t m_deps [`BE_NUM_REGS];
    backend_types_pkg::reg_idx_t m_rob_rd [1:`BE_ROB_DEPTH];
    backend_types_pkg::xlen_t    m_rob_val [1:`BE_ROB_DEPTH];
    logic                        m_rob_done [1:`BE_ROB_DEPTH];
    backend_types_pkg::rob_tag_t m_head;
    backend_types_pkg::rob_tag_t m_tail;
    int                          m_count;       // live tags
    logic                        m_ret_valid;   // retirement landing at the next edge
    backend_types_pkg::retire_t  m_ret;
    logic                        m_op_valid;
    backend_types_pkg::operand_t m_op1;
    backend_types_pkg::operand_t m_op2;
    backend_types_pkg::rob_tag_t m_outstanding [$];  // issued, no writeback yet

    int checks;
    int mismatches;
    int timeouts;
    bit aborted;

    `include "tb_vectors.svh"

    ooo_backend_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input backend_types_pkg::rob_tag_t got,
                             input backend_types_pkg::rob_tag_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input backend_types_pkg::xlen_t got,
                              input backend_types_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_pkg::axil_resp_e got,
                              input axil_pkg::axil_resp_e exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // value counts only when ready, tag only when not
    task automatic check_operand(input string name, input backend_types_pkg::operand_t got,
                                 input backend_types_pkg::operand_t exp);
        checks++;
        if (got.ready !== exp.ready || (exp.ready && got.value !== exp.value) ||
            (!exp.ready && got.tag !== exp.tag)) begin
            mismatches++;
            $display("MISMATCH %s got 0x%09h expected 0x%09h", name, got, exp);
        end
    endtask

    function automatic backend_types_pkg::operand_t model_operand(
        input backend_types_pkg::reg_idx_t idx
    );
        backend_types_pkg::operand_t op;
        op.ready = (m_deps[idx] == '0);
        op.tag   = m_deps[idx];
        op.value = op.ready ? m_regs[idx] : '0;
        return op;
    endfunction

    // what the DUT does at the coming rising edge, given the inputs now driven
    task automatic model_step();
        logic ready;
        ready = (m_count != `BE_ROB_DEPTH);
        check_flag("issue_ready", issue_ready, ready);
        if (m_ret_valid && m_ret.rd != '0) begin   // retire before lookup
            m_regs[m_ret.rd] = m_ret.value;
            if (m_deps[m_ret.rd] == m_ret.tag) begin
                m_deps[m_ret.rd] = '0;
            end
        end
        if (m_ret_valid) begin
            m_count--;
        end
        m_op_valid = issue_valid && ready;
        if (m_op_valid) begin
            m_op1 = model_operand(issue_req.rs1);
            m_op2 = model_operand(issue_req.rs2);
            if (issue_req.rd != '0) begin
                m_deps[issue_req.rd] = m_tail;
            end
            m_rob_rd[m_tail]   = issue_req.rd;
            m_rob_done[m_tail] = 1'b0;
            m_outstanding.push_back(m_tail);
            m_tail = (m_tail == `BE_ROB_DEPTH) ? 3'd1 : m_tail + 3'd1;
            m_count++;
        end
        if (wb_valid) begin
            m_rob_done[wb.tag] = 1'b1;
            m_rob_val[wb.tag]  = wb.value;
        end
        m_ret_valid = m_rob_done[m_head];
        if (m_ret_valid) begin
            m_ret.rd           = m_rob_rd[m_head];
            m_ret.tag          = m_head;
            m_ret.value        = m_rob_val[m_head];
            m_rob_done[m_head] = 1'b0;
            m_head = (m_head == `BE_ROB_DEPTH) ? 3'd1 : m_head + 3'd1;
        end
    endtask

    task automatic tick();
        model_step();
        @(posedge clk);
        @(negedge clk);
        check_flag("op_valid", op_valid, m_op_valid);
        if (m_op_valid) begin
            check_operand("op1", op1, m_op1);
            check_operand("op2", op2, m_op2);
        end
    endtask

    task automatic apply_issue(input vec_t v);
        int waited;
        waited = 0;
        issue_valid   = 1'b1;
        issue_req.rs1 = v.a[4:0];
        issue_req.rs2 = v.b;
        issue_req.rd  = v.c;
        while (!issue_ready && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!issue_ready) begin
            $display("timeout: issue_ready stayed low for %0d cycles", TIMEOUT);
            timeouts++;
            aborted = 1'b1;
        end else begin
            tick();
            check_tag("op_tag", op_tag, v.exp_tag);
        end
        issue_valid = 1'b0;
    endtask

    task automatic apply_writeback(input backend_types_pkg::rob_tag_t tag);
        wb_valid = 1'b1;
        wb.tag   = tag;
        wb.value = $urandom;
        tick();
        wb_valid = 1'b0;
        for (int i = 0; i < m_outstanding.size(); i++) begin
            if (m_outstanding[i] == tag) begin
                m_outstanding.delete(i);
                break;
            end
        end
    endtask

    task automatic writeback_shuffled();
        backend_types_pkg::rob_tag_t order [$];
        backend_types_pkg::rob_tag_t swap;
        int                          j;
        order = m_outstanding;
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            swap     = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        foreach (order[k]) begin
            apply_writeback(order[k]);
        end
    endtask

    task automatic axi_read(input vec_t v);
        axil_pkg::axil_r_t exp;
        axil_pkg::axil_r_t held;
        int                waited;
        ar_valid      = 1'b1;
        ar.araddr     = v.a;
        ar.arprot     = 3'b000;
        waited        = 0;
        while (!ar_ready && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!ar_ready) begin
            $display("timeout: ar_ready stayed low for %0d cycles", TIMEOUT);
            timeouts++;
            aborted  = 1'b1;
            ar_valid = 1'b0;
            return;
        end
        exp.rresp = v.exp_resp;
        exp.rdata = (v.exp_resp == axil_pkg::OKAY) ? m_regs[v.a[6:2]] : '0;
        tick();                                     // AR handshake
        ar_valid = 1'b0;
        check_flag("r_valid", r_valid, 1'b1);      // one cycle after the handshake
        waited   = 0;
        while (!r_valid && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!r_valid) begin
            $display("timeout: no read response for address 0x%02h", v.a);
            timeouts++;
            aborted = 1'b1;
        end else begin
            held = r;
            repeat (v.b) begin
                tick();
                check_flag("r_valid", r_valid, 1'b1);
                check_word("rdata", r.rdata, held.rdata);
                check_resp("rresp", r.rresp, held.rresp);
            end
            check_word("rdata", r.rdata, exp.rdata);
            check_resp("rresp", r.rresp, exp.rresp);
            r_ready = 1'b1;
            tick();
            r_ready = 1'b0;
            check_flag("r_valid", r_valid, 1'b0);
            check_flag("ar_ready", ar_ready, 1'b1);  // back in idle
        end
    endtask

    initial begin
        void'($urandom(75));
        rst         = 1'b0;
        issue_valid = 1'b0;
        issue_req   = '0;
        wb_valid    = 1'b0;
        wb          = '0;
        ar_valid    = 1'b0;
        ar          = '0;
        r_ready     = 1'b0;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        aborted     = 1'b0;
        for (int i = 0; i < `BE_NUM_REGS; i++) begin
            m_regs[i] = '0;
            m_deps[i] = '0;
        end
        for (int t = 1; t <= `BE_ROB_DEPTH; t++) begin
            m_rob_done[t] = 1'b0;
        end
        m_head      = 3'd1;
        m_tail      = 3'd1;
        m_count     = 0;
        m_ret_valid = 1'b0;
        m_op_valid  = 1'b0;
        load_vectors();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_flag("ar_ready", ar_ready, 1'b1);
        check_flag("r_valid", r_valid, 1'b0);
        check_flag("op_valid", op_valid, 1'b0);

        foreach (vectors[n]) begin
            if (!aborted) begin
                case (vectors[n].op)
                    OP_ISSUE:  apply_issue(vectors[n]);
                    OP_WB:     apply_writeback(vectors[n].a[2:0]);
                    OP_WB_ALL: writeback_shuffled();
                    OP_READ:   axi_read(vectors[n]);
                    default:   repeat (vectors[n].a) tick();
                endcase
            end
        end

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/ooo_backend_top.sv */
module ooo_backend_top (
    input  logic                          clk,
    input  logic                          rst,
    // issue
    input  logic                          issue_valid,
    input  backend_types_pkg::issue_req_t issue_req,
    output logic                          issue_ready,
    // operands
    output logic                          op_valid,
    output backend_types_pkg::operand_t   op1,
    output backend_types_pkg::operand_t   op2,
    output backend_types_pkg::rob_tag_t   op_tag,
    // writeback
    input  logic                          wb_valid,
    input  backend_types_pkg::wb_t        wb,
    // AXI4-Lite read
    input  logic                          ar_valid,
    input  axil_pkg::axil_ar_t            ar,
    output logic                          ar_ready,
    output logic                          r_valid,
    output axil_pkg::axil_r_t             r,
    input  logic                          r_ready
);

    logic                        issue_fire;
    backend_types_pkg::rob_tag_t alloc_tag;
    logic                        retire_valid;
    backend_types_pkg::retire_t  retire;
    backend_types_pkg::reg_idx_t dbg_idx;
    backend_types_pkg::xlen_t    dbg_value;
    backend_types_pkg::rob_tag_t tag_q;   // tag of the last accepted issue

    assign issue_fire = issue_valid && issue_ready;
    assign op_tag     = tag_q;

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            tag_q <= alloc_tag;
        end
    end

    reorder_buffer u_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (issue_valid),
        .alloc_ready  (issue_ready),
        .alloc_rd     (issue_req.rd),
        .alloc_tag    (alloc_tag),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    rename_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_fire),
        .issue_req    (issue_req),
        .issue_tag    (alloc_tag),
        .retire_valid (retire_valid),
        .retire       (retire),
        .op_valid     (op_valid),
        .op1          (op1),
        .op2          (op2),
        .dbg_idx      (dbg_idx),
        .dbg_value    (dbg_value)
    );

    regfile_axil_reader u_axil (
        .clk       (clk),
        .rst       (rst),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .dbg_idx   (dbg_idx),
        .dbg_value (dbg_value)
    );

endmodule

/* verilog/regfile_axil_reader.sv */
`include "backend_consts.svh"

module regfile_axil_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ar_valid,
    input  axil_pkg::axil_ar_t          ar,
    output logic                        ar_ready,
    output logic                        r_valid,
    output axil_pkg::axil_r_t           r,
    input  logic                        r_ready,
    output backend_types_pkg::reg_idx_t dbg_idx,
    input  backend_types_pkg::xlen_t    dbg_value
);

    typedef enum logic {
        IDLE,
        RESP
    } state_e;

    state_e state;
    logic   addr_ok;

    // word address into the register array
    assign dbg_idx  = ar.araddr[`BE_REG_IDX_W+1:2];
    assign addr_ok  = (ar.araddr[1:0] == 2'b00) &&
                      (ar.araddr < `BE_AXIL_ADDR_W'(`BE_NUM_REGS * 4));
    assign ar_ready = (state == IDLE);
    assign r_valid  = (state == RESP);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (ar_valid) state <= RESP;
                RESP: if (r_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // response held stable until accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && ar_valid) begin
            if (addr_ok) begin
                r.rdata <= dbg_value;
                r.rresp <= axil_pkg::OKAY;
            end else begin
                r.rdata <= '0;
                r.rresp <= axil_pkg::SLVERR;
            end
        end
    end

endmodule

/* verilog/reorder_buffer.sv */
`include "backend_consts.svh"

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    // tag allocation
    input  logic                        alloc_valid,
    output logic                        alloc_ready,
    input  backend_types_pkg::reg_idx_t alloc_rd,
    output backend_types_pkg::rob_tag_t alloc_tag,
    // results, any order
    input  logic                        wb_valid,
    input  backend_types_pkg::wb_t      wb,
    // in-order retirement
    output logic                        retire_valid,
    output backend_types_pkg::retire_t  retire
);

    // entry storage, slot = tag - 1
    backend_types_pkg::reg_idx_t entry_rd    [`BE_ROB_DEPTH];
    backend_types_pkg::xlen_t    entry_value [`BE_ROB_DEPTH];
    logic [`BE_ROB_DEPTH-1:0]    entry_done;

    backend_types_pkg::rob_tag_t head_tag;
    backend_types_pkg::rob_tag_t tail_tag;
    logic [`BE_TAG_W-1:0]        count;       // tags handed out and not yet freed

    logic                        alloc_fire;
    logic                        head_ready;
    backend_types_pkg::xlen_t    head_value;

    function automatic backend_types_pkg::rob_tag_t next_tag(
        input backend_types_pkg::rob_tag_t tag
    );
        if (tag == `BE_TAG_W'(`BE_ROB_DEPTH)) begin
            return `BE_TAG_W'(1);   // skip tag 0
        end
        return tag + 1'b1;
    endfunction

    function automatic logic [`BE_TAG_W-1:0] slot(
        input backend_types_pkg::rob_tag_t tag
    );
        return tag - 1'b1;
    endfunction

    assign alloc_ready = (count != `BE_TAG_W'(`BE_ROB_DEPTH));
    assign alloc_tag   = tail_tag;
    assign alloc_fire  = alloc_valid && alloc_ready;

    // head may complete in the same cycle it retires from
    always_comb begin
        head_ready = entry_done[slot(head_tag)];
        head_value = entry_value[slot(head_tag)];
        if (wb_valid && wb.tag == head_tag) begin
            head_ready = 1'b1;
            head_value = wb.value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers, occupancy and done flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            head_tag     <= `BE_TAG_W'(1);
            tail_tag     <= `BE_TAG_W'(1);
            count        <= '0;
            entry_done   <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= head_ready;
            if (alloc_fire) begin
                tail_tag                     <= next_tag(tail_tag);
                entry_done[slot(tail_tag)]   <= 1'b0;
            end
            if (wb_valid) begin
                entry_done[slot(wb.tag)] <= 1'b1;
            end
            if (head_ready) begin
                head_tag                   <= next_tag(head_tag);
                entry_done[slot(head_tag)] <= 1'b0;   // slot is empty again
            end
            // tag is freed while its retirement is on the output
            count <= count + `BE_TAG_W'(alloc_fire) - `BE_TAG_W'(retire_valid);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entry_rd[slot(tail_tag)] <= alloc_rd;
        end
        if (wb_valid) begin
            entry_value[slot(wb.tag)] <= wb.value;
        end
        if (head_ready) begin
            retire.rd    <= entry_rd[slot(head_tag)];
            retire.tag   <= head_tag;
            retire.value <= head_value;
        end
    end

endmodule

/* verilog/rename_regfile.sv */
`include "backend_consts.svh"

module rename_regfile (
    input  logic                          clk,
    input  logic                          rst,
    // accepted issue transfer
    input  logic                          issue_valid,
    input  backend_types_pkg::issue_req_t issue_req,
    input  backend_types_pkg::rob_tag_t   issue_tag,
    // in-order retirement
    input  logic                          retire_valid,
    input  backend_types_pkg::retire_t    retire,
    // operands, one cycle after issue
    output logic                          op_valid,
    output backend_types_pkg::operand_t   op1,
    output backend_types_pkg::operand_t   op2,
    // debug read
    input  backend_types_pkg::reg_idx_t   dbg_idx,
    output backend_types_pkg::xlen_t      dbg_value
);

    backend_types_pkg::xlen_t    regs [`BE_NUM_REGS];
    backend_types_pkg::rob_tag_t deps [`BE_NUM_REGS];

    logic                        retire_en;  // x0 never takes a write
    backend_types_pkg::operand_t look1;
    backend_types_pkg::operand_t look2;

    // operand as seen after this cycle's retirement
    function automatic backend_types_pkg::operand_t lookup(
        input backend_types_pkg::reg_idx_t idx,
        input backend_types_pkg::xlen_t    reg_value,
        input backend_types_pkg::rob_tag_t reg_dep,
        input logic                        ret_en,
        input backend_types_pkg::retire_t  ret
    );
        backend_types_pkg::operand_t op;
        op.value = reg_value;
        op.tag   = reg_dep;
        if (ret_en && ret.rd == idx) begin
            op.value = ret.value;
            if (reg_dep == ret.tag) begin
                op.tag = '0;   // matching producer just left
            end
        end
        op.ready = (op.tag == '0);
        if (op.ready == 1'b0) begin
            op.value = '0;
        end
        return op;
    endfunction

    assign retire_en = retire_valid && (retire.rd != '0);

    always_comb begin
        look1 = lookup(issue_req.rs1, regs[issue_req.rs1], deps[issue_req.rs1],
                       retire_en, retire);
        look2 = lookup(issue_req.rs2, regs[issue_req.rs2], deps[issue_req.rs2],
                       retire_en, retire);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // architectural state and dependency table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `BE_NUM_REGS; i++) begin
                regs[i] <= '0;
                deps[i] <= '0;
            end
        end else begin
            if (retire_en) begin
                regs[retire.rd] <= retire.value;
                if (deps[retire.rd] == retire.tag) begin
                    deps[retire.rd] <= '0;
                end
            end
            // younger claim overrides the clear above
            if (issue_valid && issue_req.rd != '0) begin
                deps[issue_req.rd] <= issue_tag;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op1 <= look1;
            op2 <= look2;
        end
    end

    assign dbg_value = regs[dbg_idx];   // retired state only

endmodule

/* verilog/axil_pkg.sv */
`include "backend_consts.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // read address channel
    typedef struct packed {
        logic [`BE_AXIL_ADDR_W-1:0] araddr;
        logic [2:0]                 arprot;
    } axil_ar_t;

    // read data channel
    typedef struct packed {
        logic [`BE_XLEN-1:0] rdata;
        axil_resp_e          rresp;
    } axil_r_t;

endpackage

/* verilog/backend_types_pkg.sv */
`include "backend_consts.svh"

package backend_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scalar types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`BE_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`BE_XLEN-1:0]      xlen_t;
    typedef logic [`BE_TAG_W-1:0]     rob_tag_t;  // zero means no producer

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } issue_req_t;

    // value valid when ready, tag valid otherwise
    typedef struct packed {
        logic     ready;
        xlen_t    value;
        rob_tag_t tag;
    } operand_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // completion side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        rob_tag_t tag;
        xlen_t    value;
    } wb_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;    // used for the dependency match
        xlen_t    value;
    } retire_t;

endpackage

/* include/backend_consts.svh */
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BE_NUM_REGS     32
`define BE_REG_IDX_W    5
`define BE_XLEN         32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reorder buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BE_TAG_W        3
`define BE_ROB_DEPTH    7   // live tags 1..7, tag 0 means ready

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BE_AXIL_ADDR_W  8   // byte address, index * 4

`endif
